// File: logic/loopPkg.sv
`default_nettype none

package loopPkg;

  // ********************
  // widths and sizes
  // ********************
  localparam int countWidth = 14;
  localparam int addrWidth  = 10;
  localparam int stackDepth = 4;
  localparam int ptrWidth   = 3;  // top bit set means the stack is empty.
  localparam int instrWidth = 28;

  // instruction word is opcode, then count, then end address.
  localparam int opcodeMsb = instrWidth - 1;
  localparam int opcodeLsb = instrWidth - 4;
  localparam int countLsb  = addrWidth;

  typedef enum logic [3:0] {
    opNop    = 4'h0,
    opDo     = 4'h1,
    opBreak  = 4'h2,
    opCntWr  = 4'h3,
    opClrErr = 4'h4
  } loopOpcode;

  typedef struct packed {
    logic                  doLoop;
    logic                  breakLoop;
    logic                  cntWr;
    logic                  clrErr;
    logic [countWidth-1:0] count;
    logic [addrWidth-1:0]  endAddr;
  } loopOp;

  typedef struct packed {
    logic [addrWidth-1:0] startAddr;
    logic [addrWidth-1:0] endAddr;
  } loopFrame;

  // single-cycle pulses from execute to result.
  typedef struct packed {
    logic loopBack;
    logic loopExit;
    logic pushDropped;
    logic popDropped;
  } loopEvent;

endpackage

`default_nettype wire

// File: logic/loopDecode.sv
`timescale 1ns/1ps
`default_nettype none

module loopDecode (
  input  logic                           instrValid,
  input  logic [loopPkg::instrWidth-1:0] instr,
  output loopPkg::loopOp                 op
);
  import loopPkg::*;

  loopOpcode             opcode;
  logic [countWidth-1:0] count;
  logic [addrWidth-1:0]  endAddr;

  assign opcode  = loopOpcode'(instr[opcodeMsb:opcodeLsb]);
  assign count   = instr[opcodeLsb-1:countLsb];
  assign endAddr = instr[addrWidth-1:0];

  always_comb begin
    op = '0;
    if (instrValid) begin
      case (opcode)
        opDo: begin
          op.doLoop  = 1'b1;
          op.count   = (count == '0) ? countWidth'(1) : count;  // zero runs once.
          op.endAddr = endAddr;
        end
        opBreak: begin
          op.breakLoop = 1'b1;
        end
        opCntWr: begin
          op.cntWr = 1'b1;
          op.count = count;
        end
        opClrErr: begin
          op.clrErr = 1'b1;
        end
        default: begin
          op = '0;  // NOP and unknown opcodes do nothing.
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/loopStack.sv
`timescale 1ns/1ps
`default_nettype none

module loopStack #(
  parameter type payload_t = logic [loopPkg::countWidth-1:0]
) (
  input  logic     CNSCLK,
  input  logic     T_RST,
  input  logic     enable,
  input  logic     push,
  input  logic     pop,
  input  logic     replace,
  input  payload_t din,
  output payload_t top,
  output logic     full,
  output logic     empty,
  output logic     hasOne
);
  import loopPkg::*;

  payload_t            mem [stackDepth];
  logic [ptrWidth-1:0] ptr;
  logic [ptrWidth-1:0] ptrUp;
  logic [ptrWidth-1:0] ptrDown;
  logic [ptrWidth-2:0] writeAddr;
  logic                doPush;
  logic                doPop;
  logic                doWrite;

  // ptr points at the top entry; all ones after reset.
  assign empty  = ptr[ptrWidth-1];
  assign full   = (ptr == ptrWidth'(stackDepth - 1));
  assign hasOne = (ptr == '0);

  assign doPush = push && !full && enable;   // push into a full stack is dropped.
  assign doPop  = pop && !empty && enable;   // so is a pop from an empty one.

  assign ptrUp   = ptr + 1'b1;
  assign ptrDown = ptr - 1'b1;

  // replace rewrites the current top in place.
  assign doWrite   = doPush || (replace && !empty && enable);
  assign writeAddr = doPush ? ptrUp[ptrWidth-2:0] : ptr[ptrWidth-2:0];

  always_ff @(posedge CNSCLK or posedge T_RST) begin
    if (T_RST) begin
      ptr <= '1;
    end else if (doPush) begin
      ptr <= ptrUp;
    end else if (doPop) begin
      ptr <= ptrDown;
    end
  end

  always_ff @(posedge CNSCLK) begin
    if (doWrite) begin
      mem[writeAddr] <= din;
    end
  end

  assign top = mem[ptr[ptrWidth-2:0]];

endmodule

`default_nettype wire

// File: logic/loopExecute.sv
`timescale 1ns/1ps
`default_nettype none

module loopExecute (
  input  logic                           CNSCLK,
  input  logic                           T_RST,
  input  logic                           clkEnb,
  input  loopPkg::loopOp                 op,
  input  logic [loopPkg::addrWidth-1:0]  pc,
  output loopPkg::loopEvent              evt,
  output logic [loopPkg::addrWidth-1:0]  startAddr,
  output logic [loopPkg::countWidth-1:0] topCount,
  output logic                           empty,
  output logic                           full,
  output logic                           hasOne
);
  import loopPkg::*;

  logic                  stackEnb;
  logic                  cntEmpty;
  logic                  cntFull;
  logic                  push;
  logic                  pop;
  logic                  replace;
  logic                  loopEnd;
  logic                  moreLeft;
  logic [countWidth-1:0] cntIn;
  loopFrame              frameIn;
  loopFrame              frameTop;
  logic [ptrWidth-1:0]   depth;
  logic [ptrWidth-1:0]   nextDepth;

  assign stackEnb = !clkEnb;  // clkEnb high freezes everything.

  // ********************
  // loop-end detection
  // ********************
  assign loopEnd  = !cntEmpty && (pc == frameTop.endAddr) && !op.doLoop && !op.breakLoop;
  assign moreLeft = (topCount > countWidth'(1));

  always_comb begin
    evt.loopBack    = loopEnd && moreLeft;
    evt.loopExit    = loopEnd && !moreLeft;
    evt.pushDropped = op.doLoop && cntFull;
    evt.popDropped  = op.breakLoop && cntEmpty;
  end

  // a loop end overrides CNTWR in the same cycle.
  assign push    = op.doLoop;
  assign pop     = op.breakLoop || evt.loopExit;
  assign replace = evt.loopBack || (op.cntWr && !op.doLoop && !op.breakLoop && !loopEnd);

  assign cntIn             = evt.loopBack ? (topCount - countWidth'(1)) : op.count;
  assign frameIn.startAddr = pc + addrWidth'(1);
  assign frameIn.endAddr   = op.endAddr;

  loopStack #(.payload_t(logic [countWidth-1:0])) u_countStack (
    .CNSCLK (CNSCLK),
    .T_RST  (T_RST),
    .enable (stackEnb),
    .push   (push),
    .pop    (pop),
    .replace(replace),
    .din    (cntIn),
    .top    (topCount),
    .full   (cntFull),
    .empty  (cntEmpty),
    .hasOne ()
  );

  // frames move in step with counts, so their flags are left open.
  loopStack #(.payload_t(loopFrame)) u_frameStack (
    .CNSCLK (CNSCLK),
    .T_RST  (T_RST),
    .enable (stackEnb),
    .push   (push),
    .pop    (pop),
    .replace(1'b0),
    .din    (frameIn),
    .top    (frameTop),
    .full   (),
    .empty  (),
    .hasOne ()
  );

  assign startAddr = frameTop.startAddr;

  // ********************
  // next-state flags
  // ********************
  always_comb begin
    nextDepth = depth;
    if (stackEnb && push && !cntFull) begin
      nextDepth = depth + 1'b1;
    end else if (stackEnb && pop && !cntEmpty) begin
      nextDepth = depth - 1'b1;
    end
  end

  always_ff @(posedge CNSCLK or posedge T_RST) begin
    if (T_RST) begin
      depth <= '0;
    end else begin
      depth <= nextDepth;
    end
  end

  assign empty  = (nextDepth == '0);
  assign hasOne = (nextDepth == ptrWidth'(1));
  assign full   = (nextDepth == ptrWidth'(stackDepth));  // matches the stacks after the edge.

endmodule

`default_nettype wire

// File: logic/loopResult.sv
`timescale 1ns/1ps
`default_nettype none

module loopResult (
  input  logic                          CNSCLK,
  input  logic                          T_RST,
  input  logic                          clkEnb,
  input  loopPkg::loopEvent             evt,
  input  logic                          clrErr,
  input  logic [loopPkg::addrWidth-1:0] pc,
  input  logic [loopPkg::addrWidth-1:0] startAddr,
  input  logic                          empty,
  input  logic                          full,
  input  logic                          hasOne,
  output logic [loopPkg::addrWidth-1:0] nextPc,
  output logic                          loopTaken,
  output logic                          stackEmpty,
  output logic                          stackFull,
  output logic                          lastPass,
  output logic                          stackError
);
  import loopPkg::*;

  logic dropped;

  // branch back on a loop end, otherwise fall through.
  assign loopTaken = evt.loopBack;
  assign nextPc    = evt.loopBack ? startAddr : pc + addrWidth'(1);  // wraps at 10 bits.

  assign dropped = evt.pushDropped || evt.popDropped;

  // ********************
  // status registers
  // ********************
  always_ff @(posedge CNSCLK or posedge T_RST) begin
    if (T_RST) begin
      stackEmpty <= 1'b1;
      stackFull  <= 1'b0;
      lastPass   <= 1'b0;
      stackError <= 1'b0;
    end else if (!clkEnb) begin
      stackEmpty <= empty;
      stackFull  <= full;
      lastPass   <= hasOne;
      if (dropped) begin
        stackError <= 1'b1;  // a new error wins over CLRERR.
      end else if (clrErr) begin
        stackError <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/loopSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module loopSequencer (
  input  logic                           CNSCLK,
  input  logic                           T_RST,
  input  logic                           clkEnb,
  input  logic                           instrValid,
  input  logic [loopPkg::instrWidth-1:0] instr,
  input  logic [loopPkg::addrWidth-1:0]  pc,
  output logic [loopPkg::addrWidth-1:0]  nextPc,
  output logic                           loopTaken,
  output logic [loopPkg::countWidth-1:0] topCount,
  output logic                           stackEmpty,
  output logic                           stackFull,
  output logic                           lastPass,
  output logic                           stackError
);
  import loopPkg::*;

  loopOp                op;
  loopEvent             evt;
  logic [addrWidth-1:0] startAddr;
  logic                 empty;
  logic                 full;
  logic                 hasOne;

  loopDecode u_decode (
    .instrValid(instrValid),
    .instr     (instr),
    .op        (op)
  );

  loopExecute u_execute (
    .CNSCLK   (CNSCLK),
    .T_RST    (T_RST),
    .clkEnb   (clkEnb),
    .op       (op),
    .pc       (pc),
    .evt      (evt),
    .startAddr(startAddr),
    .topCount (topCount),
    .empty    (empty),
    .full     (full),
    .hasOne   (hasOne)
  );

  loopResult u_result (
    .CNSCLK    (CNSCLK),
    .T_RST     (T_RST),
    .clkEnb    (clkEnb),
    .evt       (evt),
    .clrErr    (op.clrErr),
    .pc        (pc),
    .startAddr (startAddr),
    .empty     (empty),
    .full      (full),
    .hasOne    (hasOne),
    .nextPc    (nextPc),
    .loopTaken (loopTaken),
    .stackEmpty(stackEmpty),
    .stackFull (stackFull),
    .lastPass  (lastPass),
    .stackError(stackError)
  );

endmodule

`default_nettype wire

// File: sim/loopClock.sv
`timescale 1ns/1ps
`default_nettype none

module loopClock (
  output logic CNSCLK,
  output logic T_RST
);

  // 100 ns period.
  initial begin
    CNSCLK = 1'b0;
    forever begin
      #50 CNSCLK = ~CNSCLK;
    end
  end

  initial begin
    T_RST = 1'b1;
    repeat (10) @(posedge CNSCLK);
    T_RST <= 1'b0;  // released on a clock edge, like any other input.
  end

endmodule

`default_nettype wire

// File: sim/loopStack_properties.sv
`timescale 1ns/1ps
`default_nettype none

module loopStackProperties (
  input logic                         CNSCLK,
  input logic                         T_RST,
  input logic                         push,
  input logic                         pop,
  input logic                         full,
  input logic                         empty,
  input logic [loopPkg::ptrWidth-1:0] ptr
);
  import loopPkg::*;

  // full is never followed by empty, nor empty by full.
  notFullAndEmpty: assert property (@(posedge CNSCLK) disable iff (T_RST)
    !($past(full) && empty) && !($past(empty) && full))
    else $error("stack went between full and empty in a single cycle.");

  // legal pointers are 0 to 3, or all ones for an empty stack.
  ptrInRange: assert property (@(posedge CNSCLK) disable iff (T_RST)
    (ptr < ptrWidth'(stackDepth)) || (ptr == '1))
    else $error("stack pointer left its legal range.");

  pushWhileFull: assert property (@(posedge CNSCLK) disable iff (T_RST)
    (push && full && !pop) |=> (ptr == $past(ptr)))
    else $error("push into a full stack moved the pointer.");

endmodule

bind loopStack loopStackProperties u_stackProps (
  .CNSCLK(CNSCLK),
  .T_RST (T_RST),
  .push  (push),
  .pop   (pop),
  .full  (full),
  .empty (empty),
  .ptr   (ptr)
);

`default_nettype wire

// File: sim/loopTb.sv
`timescale 1ns/1ps
`default_nettype none

module loopTb;
  import loopPkg::*;

  typedef struct packed {
    logic [7:0]            testId;
    logic                  clkEnb;
    logic                  instrValid;
    logic [instrWidth-1:0] instr;
    logic [addrWidth-1:0]  pc;
    logic [addrWidth-1:0]  nextPc;
    logic                  loopTaken;
    logic [countWidth-1:0] topCount;
    logic                  stackEmpty;
    logic                  stackFull;
    logic                  lastPass;
    logic                  stackError;
    logic [6:0]            mask;  // bit 0 is nextPc, bit 6 is stackError.
  } vectorLine;

  logic                  CNSCLK;
  logic                  T_RST;
  logic                  clkEnb;
  logic                  instrValid;
  logic [instrWidth-1:0] instr;
  logic [addrWidth-1:0]  pc;
  logic [addrWidth-1:0]  nextPc;
  logic                  loopTaken;
  logic [countWidth-1:0] topCount;
  logic                  stackEmpty;
  logic                  stackFull;
  logic                  lastPass;
  logic                  stackError;

  vectorLine vectors[$];
  string     curName;
  int        curId;
  int        testCount;
  int        checkCount;
  int        errorCount;
  int        testChecks;
  int        testErrors;
  int        cycleCount;
  int        cycleLimit;

  loopClock u_clock (
    .CNSCLK(CNSCLK),
    .T_RST (T_RST)
  );

  loopSequencer u_dut (
    .CNSCLK    (CNSCLK),
    .T_RST     (T_RST),
    .clkEnb    (clkEnb),
    .instrValid(instrValid),
    .instr     (instr),
    .pc        (pc),
    .nextPc    (nextPc),
    .loopTaken (loopTaken),
    .topCount  (topCount),
    .stackEmpty(stackEmpty),
    .stackFull (stackFull),
    .lastPass  (lastPass),
    .stackError(stackError)
  );

  function automatic string testName(input int id);
    case (id)
      1: return "reset";
      2: return "singleLoop";
      3: return "nestedLoops";
      4: return "stackError";
      5: return "cntWrAndZeroCount";
      6: return "clockEnable";
      default: return "unknown";
    endcase
  endfunction

  task automatic readVectors();
    int          fd;
    int          got;
    int          id;
    int          ce;
    int          iv;
    int          taken;
    int          emptyVal;
    int          fullVal;
    int          lastVal;
    int          errVal;
    logic [31:0] insVal;
    logic [31:0] pcVal;
    logic [31:0] nextVal;
    logic [31:0] topVal;
    logic [31:0] maskVal;
    string       text;
    vectorLine   v;
    fd = $fopen("sim/loopVectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file sim/loopVectors.txt");
      errorCount++;
      return;
    end
    while (!$feof(fd)) begin
      text = "";
      got  = $fgets(text, fd);
      if (got > 0 && text.getc(0) != 8'h23) begin  // lines starting with # are comments.
        got = $sscanf(text, "%d %d %d %h %h %h %d %h %d %d %d %d %h", id, ce, iv, insVal,
                      pcVal, nextVal, taken, topVal, emptyVal, fullVal, lastVal, errVal, maskVal);
        if (got == 13) begin
          v.testId     = 8'(id);
          v.clkEnb     = 1'(ce);
          v.instrValid = 1'(iv);
          v.instr      = instrWidth'(insVal);
          v.pc         = addrWidth'(pcVal);
          v.nextPc     = addrWidth'(nextVal);
          v.loopTaken  = 1'(taken);
          v.topCount   = countWidth'(topVal);
          v.stackEmpty = 1'(emptyVal);
          v.stackFull  = 1'(fullVal);
          v.lastPass   = 1'(lastVal);
          v.stackError = 1'(errVal);
          v.mask       = 7'(maskVal);
          vectors.push_back(v);
        end
      end
    end
    $fclose(fd);
    if (vectors.size() == 0) begin
      $display("no test vectors were loaded");
      errorCount++;
    end
  endtask

  task automatic compareField(input string field, input logic [15:0] expected,
                              input logic [15:0] actual);
    checkCount++;
    testChecks++;
    assert (actual === expected) else begin
      $display("MISMATCH %s %s: expected %0h, actual %0h", curName, field, expected, actual);
      errorCount++;
      testErrors++;
    end
  endtask

  task automatic checkOutputs(input vectorLine v);
    if (v.mask[0]) compareField("nextPc", 16'(v.nextPc), 16'(nextPc));
    if (v.mask[1]) compareField("loopTaken", 16'(v.loopTaken), 16'(loopTaken));
    if (v.mask[2]) compareField("topCount", 16'(v.topCount), 16'(topCount));
    if (v.mask[3]) compareField("stackEmpty", 16'(v.stackEmpty), 16'(stackEmpty));
    if (v.mask[4]) compareField("stackFull", 16'(v.stackFull), 16'(stackFull));
    if (v.mask[5]) compareField("lastPass", 16'(v.lastPass), 16'(lastPass));
    if (v.mask[6]) compareField("stackError", 16'(v.stackError), 16'(stackError));
  endtask

  task automatic reportTest();
    if (curId > 0) begin
      $display("test %0d %s done: %0d checks, %0d errors", curId, curName, testChecks, testErrors);
      testCount++;
    end
    testChecks = 0;
    testErrors = 0;
  endtask

  // ********************
  // stimulus and checks
  // ********************
  initial begin
    vectorLine             v;
    logic [instrWidth-1:0] instrWord;
    void'($urandom(32'h7e43));
    clkEnb     = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    pc         = '0;
    curId      = 0;
    curName    = "";
    testCount  = 0;
    checkCount = 0;
    errorCount = 0;
    cycleCount = 0;
    readVectors();
    cycleLimit = vectors.size() + 20;

    @(posedge CNSCLK);
    while (T_RST) begin
      @(posedge CNSCLK);
    end

    foreach (vectors[i]) begin
      v = vectors[i];
      if (int'(v.testId) != curId) begin
        reportTest();
        curId   = int'(v.testId);
        curName = testName(curId);
      end
      instrWord = v.instr;
      if (instrWord[opcodeMsb:opcodeLsb] == opNop) begin
        instrWord[opcodeLsb-1:0] = opcodeLsb'($urandom);  // NOP fields are don't care.
      end
      clkEnb     <= v.clkEnb;
      instrValid <= v.instrValid;
      instr      <= instrWord;
      pc         <= v.pc;
      @(negedge CNSCLK);
      checkOutputs(v);  // outputs have settled by the falling edge.
      @(posedge CNSCLK);
    end
    reportTest();

    $display("totals: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  always @(posedge CNSCLK) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      $display("timed out after %0d cycles before all vectors were applied", cycleCount);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: sim/loopVectors.txt
# id clkEnb instrValid instr pc, then expected nextPc loopTaken topCount empty full lastPass error mask
# mask bits: 0 nextPc, 1 loopTaken, 2 topCount, 3 stackEmpty, 4 stackFull, 5 lastPass, 6 stackError
1 0 0 0000000 005 006 0 0000 1 0 0 0 7b
1 0 0 0000000 3ff 000 0 0000 1 0 0 0 7b
2 0 1 1000c12 010 011 0 0000 1 0 0 0 7b
2 0 1 0000000 011 012 0 0003 0 0 1 0 7f
2 0 1 0000000 012 011 1 0003 0 0 1 0 7f
2 0 1 0000000 011 012 0 0002 0 0 1 0 7f
2 0 1 0000000 012 011 1 0002 0 0 1 0 7f
2 0 1 0000000 011 012 0 0001 0 0 1 0 7f
2 0 1 0000000 012 013 0 0001 0 0 1 0 7f
2 0 1 0000000 013 014 0 0000 1 0 0 0 7b
3 0 1 1000c30 020 021 0 0000 1 0 0 0 7b
3 0 1 100082c 021 022 0 0003 0 0 1 0 7f
3 0 1 1000428 022 023 0 0002 0 0 0 0 7f
3 0 1 1000825 023 024 0 0001 0 0 0 0 7f
3 0 1 1001c26 024 025 0 0002 0 1 0 0 7f
3 0 1 0000000 025 024 1 0002 0 1 0 1 7f
3 0 1 0000000 024 025 0 0001 0 1 0 1 7f
3 0 1 0000000 025 026 0 0001 0 1 0 1 7f
3 0 1 0000000 028 029 0 0001 0 0 0 1 7f
3 0 1 0000000 02c 022 1 0002 0 0 0 1 7f
3 0 1 0000000 02c 02d 0 0001 0 0 0 1 7f
3 0 1 0000000 030 021 1 0003 0 0 1 1 7f
3 0 1 2000000 021 022 0 0002 0 0 1 1 7f
4 0 1 4000000 040 041 0 0000 1 0 0 1 7b
4 0 1 2000000 041 042 0 0000 1 0 0 0 7b
4 0 1 0000000 042 043 0 0000 1 0 0 1 7b
4 0 1 4000000 043 044 0 0000 1 0 0 1 7b
4 0 1 0000000 044 045 0 0000 1 0 0 0 7b
5 0 1 1001460 050 051 0 0000 1 0 0 0 7b
5 0 1 3002400 051 052 0 0005 0 0 1 0 7f
5 0 1 0000000 052 053 0 0009 0 0 1 0 7f
5 0 1 1000058 053 054 0 0009 0 0 1 0 7f
5 0 1 0000000 054 055 0 0001 0 0 0 0 7f
5 0 1 0000000 058 059 0 0001 0 0 0 0 7f
5 0 1 0000000 059 05a 0 0009 0 0 1 0 7f
5 0 1 2000000 05a 05b 0 0009 0 0 1 0 7f
6 0 1 1000872 070 071 0 0000 1 0 0 0 7b
6 1 1 100107f 071 072 0 0002 0 0 1 0 7f
6 1 1 0000000 072 071 1 0002 0 0 1 0 7f
6 1 1 0000000 072 071 1 0002 0 0 1 0 7f
6 0 1 0000000 072 071 1 0002 0 0 1 0 7f
6 0 1 0000000 071 072 0 0001 0 0 1 0 7f
6 1 1 0000000 072 073 0 0001 0 0 1 0 7f
6 0 1 0000000 072 073 0 0001 0 0 1 0 7f
6 0 1 0000000 073 074 0 0000 1 0 0 0 7b
6 1 1 2000000 074 075 0 0000 1 0 0 0 7b
6 0 1 0000000 075 076 0 0000 1 0 0 0 7b

// File: flist.f
logic/loopPkg.sv
logic/loopDecode.sv
logic/loopStack.sv
logic/loopExecute.sv
logic/loopResult.sv
logic/loopSequencer.sv
sim/loopClock.sv
sim/loopStack_properties.sv
sim/loopTb.sv

// File: run.sh
#!/usr/bin/env bash
# Compiles the loop sequencer testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
buildLog=build.log
simLog=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module loopTb \
  -f flist.f --Mdir "$buildDir" > "$buildLog" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
  cat "$buildLog"
  echo "build failed with status $status"
  exit 1
fi

"./$buildDir/VloopTb" > "$simLog" 2>&1
status=$?
cat "$simLog"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qxF '** PASS **' "$simLog"; then
  exit 0
else
  exit 1
fi
